// File: files.f
+incdir+.
rvv_backend_pkg.sv
rvv_sync_fifo.sv
rvv_decode_unit.sv
rvv_backend_decode_ctrl.sv
rvv_backend_decode.sv
rvv_backend_decode_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the decode stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f files.f \
  --top-module rvv_backend_decode_tb \
  -o rvv_backend_decode_sim

./obj_dir/rvv_backend_decode_sim > sim.log 2>&1
cat sim.log

# result comes from the log
if grep -q "=== FAIL ===" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
exit 0

// File: rvv_backend_decode_tb.sv
/* testbench for the vector decode stage with random instructions in and uops checked out
   runs ordering, long, packing and back-pressure traffic against a queue model */

module rvv_backend_decode_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_INST    = 200;
  localparam int HOLD_CYCLES = 100;
  // 200 instructions of up to 8 uops at about 2 cycles per uop
  localparam int MAX_CYCLES  = 4000;

  logic                   clk;
  logic                   rst_n;
  logic                   inst_valid;
  rvv_backend_pkg::inst_t inst_data;
  logic                   cq_full;
  logic                   uop_valid;
  rvv_backend_pkg::uop_t  uop_data;
  logic                   uop_pop;

  // expected uops in delivery order
  rvv_backend_pkg::uop_t expected_q[$];

  integer seed;
  int     errors;
  int     checks;
  int     sent;
  int     cycles;
  string  test_name;
  logic   saw_cq_full;

  rvv_backend_decode rvv_backend_decode_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst_data  (inst_data),
    .cq_full    (cq_full),
    .uop_valid  (uop_valid),
    .uop_data   (uop_data),
    .uop_pop    (uop_pop)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // writes at most one instruction per call and queues its expected uops
  task automatic drive_source(input int min_num, input int max_num, input bit always_write,
                              input int inst_limit);
    rvv_backend_pkg::inst_t inst;
    rvv_backend_pkg::uop_t  uop;
    int unsigned            rnd;
    int unsigned            span;
    int                     pick;
    bit                     want;
    want = always_write || (($random(seed) & 1) != 0);
    inst_valid = 1'b0;
    if (want && !cq_full && sent < inst_limit) begin
      rnd          = $unsigned($random(seed));
      span         = max_num - min_num + 1;
      pick         = min_num + int'(rnd % span);
      inst.tag     = 8'(sent);
      inst.opcode  = 8'($random(seed));
      inst.uop_num = 3'(pick);
      inst_data    = inst;
      inst_valid   = 1'b1;
      for (int i = 0; i <= pick; i++) begin
        uop.tag            = inst.tag;
        uop.opcode         = inst.opcode;
        uop.uop_index      = 3'(i);
        uop.last_uop_valid = (i == pick);
        expected_q.push_back(uop);
      end
      sent++;
    end
  endtask

  // compares the head uop that is about to be popped
  task automatic check_uop();
    rvv_backend_pkg::uop_t exp;
    if (expected_q.size() == 0) begin
      $display("uop with tag %h index %0d came out while no uop was expected",
               uop_data.tag, uop_data.uop_index);
      errors++;
    end else begin
      exp = expected_q.pop_front();
      checks++;
      assert (uop_data == exp) else begin
        $display("[FAIL] %s: expected %h actual %h", test_name, exp, uop_data);
        errors++;
      end
    end
  endtask

  // random pops that may hit an empty queue
  task automatic drive_consumer(input bit pop_en);
    uop_pop = 1'b0;
    if (pop_en && (($random(seed) & 3) != 0)) begin
      uop_pop = 1'b1;
      if (uop_valid) begin
        check_uop();
      end
    end
  endtask

  task automatic check_idle_outputs();
    checks++;
    assert (!uop_valid && !cq_full) else begin
      $display("uop_valid or cq_full is high around reset (uop_valid %b, cq_full %b)",
               uop_valid, cq_full);
      errors++;
    end
  endtask

  task automatic run_traffic(input string name, input int min_num, input int max_num,
                             input int inst_limit);
    test_name = name;
    while (sent < inst_limit) begin
      @(negedge clk);
      drive_source(min_num, max_num, 1'b0, inst_limit);
      drive_consumer(1'b1);
    end
  endtask

  // consumer stalled while the source keeps writing
  task automatic hold_consumer(input int inst_limit);
    test_name   = "backpressure";
    saw_cq_full = 1'b0;
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      drive_source(0, 7, 1'b1, inst_limit);
      drive_consumer(1'b0);
      if (cq_full) begin
        saw_cq_full = 1'b1;
      end
    end
    checks++;
    assert (saw_cq_full) else begin
      $display("cq_full never rose while the consumer was stalled for %0d cycles",
               HOLD_CYCLES);
      errors++;
    end
  endtask

  task automatic drain_queues();
    test_name = "drain";
    while (expected_q.size() != 0) begin
      @(negedge clk);
      drive_source(0, 7, 1'b0, sent);
      drive_consumer(1'b1);
    end
    @(negedge clk);
    uop_pop = 1'b0;
    repeat (4) begin
      @(negedge clk);
    end
    checks++;
    assert (!uop_valid) else begin
      $display("uop queue still holds a uop after every expected uop was delivered");
      errors++;
    end
  endtask

  initial begin
    seed       = 32'h0e74ac0c;
    errors     = 0;
    checks     = 0;
    sent       = 0;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst_data  = '0;
    uop_pop    = 1'b0;
    test_name  = "reset";

    // outputs checked after each of three reset edges and after release
    repeat (3) begin
      @(negedge clk);
      check_idle_outputs();
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_idle_outputs();

    run_traffic("ordering", 0, 7, 50);
    run_traffic("long", 4, 7, 100);
    run_traffic("packing", 0, 1, 150);
    hold_consumer(NUM_INST);
    run_traffic("backpressure", 0, 7, NUM_INST);
    drain_queues();

    $display("instructions %0d, checks %0d, errors %0d", sent, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // run limit
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d uops still expected, %0d errors so far",
             cycles, expected_q.size(), errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: rvv_backend_decode.sv
/* decode stage top, command queue -> two decode units -> uop queue
   the source watches cq_full, the consumer pops with uop_pop */

`include "rvv_backend_consts.svh"

module rvv_backend_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   inst_valid,
  input  rvv_backend_pkg::inst_t inst_data,
  output logic                   cq_full,
  output logic                   uop_valid,
  output rvv_backend_pkg::uop_t  uop_data,
  input  logic                   uop_pop
);

  // command queue heads
  logic [`NUM_DE_INST-1:0]                                   head_valid;
  rvv_backend_pkg::inst_t [`NUM_DE_INST-1:0]                 head_data;
  logic [`NUM_DE_INST-1:0]                                   pop;
  logic [`UOP_INDEX_WIDTH-1:0]                               uop_index_remain;

  // decode unit outputs
  logic [`NUM_DE_INST-1:0][`NUM_DE_UOP-1:0]                  de_valid;
  rvv_backend_pkg::uop_t [`NUM_DE_INST-1:0][`NUM_DE_UOP-1:0] de_uops;

  // uop queue write side
  logic [`NUM_DE_UOP-1:0]                                    push;
  rvv_backend_pkg::uop_t [`NUM_DE_UOP-1:0]                   push_data;
  logic                                                      uq_full;
  logic [`NUM_DE_UOP-1:1]                                    uq_almost_full;

  rvv_sync_fifo #(
    .DEPTH     (`CQ_DEPTH),
    .WR_PORTS  (1),
    .RD_PORTS  (`NUM_DE_INST),
    .payload_t (rvv_backend_pkg::inst_t)
  ) cmd_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (inst_valid),
    .wr_data     (inst_data),
    .rd_en       (pop),
    .rd_valid    (head_valid),
    .rd_data     (head_data),
    .full        (cq_full),
    .almost_full ()
  );

  // unit 0 resumes a partly issued head, unit 1 always starts at 0
  rvv_decode_unit decode_unit0 (
    .inst_valid      (head_valid[0]),
    .inst            (head_data[0]),
    .uop_index_start (uop_index_remain),
    .uop_valid       (de_valid[0]),
    .uops            (de_uops[0])
  );

  rvv_decode_unit decode_unit1 (
    .inst_valid      (head_valid[1]),
    .inst            (head_data[1]),
    .uop_index_start ('0),
    .uop_valid       (de_valid[1]),
    .uops            (de_uops[1])
  );

  rvv_backend_decode_ctrl decode_ctrl (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .pkg_valid              (head_valid),
    .uop_valid_de2uq        (de_valid),
    .uop_de2uq              (de_uops),
    .uop_index_remain       (uop_index_remain),
    .pop                    (pop),
    .push                   (push),
    .dataout                (push_data),
    .fifo_full_uq2de        (uq_full),
    .fifo_almost_full_uq2de (uq_almost_full)
  );

  rvv_sync_fifo #(
    .DEPTH     (`UQ_DEPTH),
    .WR_PORTS  (`NUM_DE_UOP),
    .RD_PORTS  (1),
    .payload_t (rvv_backend_pkg::uop_t)
  ) uop_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en       (push),
    .wr_data     (push_data),
    .rd_en       (uop_pop),
    .rd_valid    (uop_valid),
    .rd_data     (uop_data),
    .full        (uq_full),
    .almost_full (uq_almost_full)
  );

endmodule

// File: rvv_backend_decode_ctrl.sv
/* packs decoded uops into uop-queue slots and pops the command queue
   writes only when the uop queue has room for a full group of uops */

`include "rvv_backend_consts.svh"

module rvv_backend_decode_ctrl (
  input  logic                                                          clk,
  input  logic                                                          rst_n,
  input  logic [`NUM_DE_INST-1:0]                                       pkg_valid,
  input  logic [`NUM_DE_INST-1:0][`NUM_DE_UOP-1:0]                      uop_valid_de2uq,
  input  rvv_backend_pkg::uop_t [`NUM_DE_INST-1:0][`NUM_DE_UOP-1:0]     uop_de2uq,
  output logic [`UOP_INDEX_WIDTH-1:0]                                   uop_index_remain,
  output logic [`NUM_DE_INST-1:0]                                       pop,
  output logic [`NUM_DE_UOP-1:0]                                        push,
  output rvv_backend_pkg::uop_t [`NUM_DE_UOP-1:0]                       dataout,
  input  logic                                                          fifo_full_uq2de,
  input  logic [`NUM_DE_UOP-1:1]                                        fifo_almost_full_uq2de
);

  localparam int IDX_W    = `UOP_INDEX_WIDTH;
  localparam int NUM_SLOT = `NUM_DE_UOP;
  localparam int QTY_W    = $clog2(`NUM_DE_UOP + 1);

  // valid lanes of unit 0 counted from lane 0
  logic [QTY_W-1:0]    quantity;
  logic [NUM_SLOT-1:0] push_valid;
  logic [`NUM_DE_INST-1:0] last_uop_unit;
  logic                fifo_ready;

  // resume index register controls
  logic                index_clear;
  logic                index_enable_unit0;
  logic                index_enable_unit1;
  logic [IDX_W-1:0]    index_din;

  assign fifo_ready = !(fifo_full_uq2de || (|fifo_almost_full_uq2de));

  always_comb begin
    quantity = '0;
    for (int j = 0; j < NUM_SLOT; j++) begin
      quantity = quantity + QTY_W'(uop_valid_de2uq[0][j]);
    end
  end

  // slot packing
  // slots below quantity take unit 0 and the rest take unit 1 from lane 0
  always_comb begin
    push_valid    = '0;
    dataout       = '0;
    last_uop_unit = '0;
    // lanes stop at the last uop so any last flag means unit 0 finishes
    for (int j = 0; j < NUM_SLOT; j++) begin
      last_uop_unit[0] = last_uop_unit[0] || uop_de2uq[0][j].last_uop_valid;
    end
    for (int s = 0; s < NUM_SLOT; s++) begin
      if (QTY_W'(s) < quantity) begin
        push_valid[s] = uop_valid_de2uq[0][s];
        dataout[s]    = uop_de2uq[0][s];
      end else begin
        push_valid[s] = uop_valid_de2uq[1][s - int'(quantity)];
        dataout[s]    = uop_de2uq[1][s - int'(quantity)];
        // unit 1 finishes only if its last uop landed in a leftover slot
        last_uop_unit[1] = last_uop_unit[1] || dataout[s].last_uop_valid;
      end
    end
  end

  assign push = push_valid & {NUM_SLOT{fifo_ready}};

  // pop[1] is only set together with pop[0]
  assign pop[0] = fifo_ready && pkg_valid[0] && last_uop_unit[0];
  assign pop[1] = pop[0] && pkg_valid[1] && last_uop_unit[1];

  // resume index
  // head 0 still busy so step past the four uops just written
  assign index_enable_unit0 = fifo_ready && pkg_valid[0] && !pop[0];
  // head 1 partly written behind head 0
  assign index_enable_unit1 = pop[0] && pkg_valid[1] && !pop[1];
  // nothing left half issued
  assign index_clear = (pop[0] && !pkg_valid[1]) || pop[1];

  always_comb begin
    index_din = uop_index_remain;
    if (index_enable_unit0) begin
      index_din = uop_index_remain + IDX_W'(NUM_SLOT);
    end else if (index_enable_unit1) begin
      index_din = IDX_W'(NUM_SLOT) - IDX_W'(quantity);
    end
  end

  // clear/enable register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      uop_index_remain <= '0;
    end else if (index_clear) begin
      uop_index_remain <= '0;
    end else if (index_enable_unit0 || index_enable_unit1) begin
      uop_index_remain <= index_din;
    end
  end

endmodule

// File: rvv_decode_unit.sv
/* expands one instruction into up to four consecutive uops
   lanes start at uop_index_start and stop after the last uop */

`include "rvv_backend_consts.svh"

module rvv_decode_unit (
  input  logic                                          inst_valid,
  input  rvv_backend_pkg::inst_t                        inst,
  input  logic [`UOP_INDEX_WIDTH-1:0]                   uop_index_start,
  output logic [`NUM_DE_UOP-1:0]                        uop_valid,
  output rvv_backend_pkg::uop_t [`NUM_DE_UOP-1:0]       uops
);

  localparam int IDX_W    = `UOP_INDEX_WIDTH;
  localparam int NUM_LANE = `NUM_DE_UOP;

  // one extra bit so start+j cannot wrap back into range
  logic [IDX_W:0] uop_num_ext;

  assign uop_num_ext = {1'b0, inst.uop_num};

  for (genvar j = 0; j < NUM_LANE; j++) begin : g_lane
    logic [IDX_W:0] lane_idx;
    logic           lane_valid;

    assign lane_idx   = {1'b0, uop_index_start} + (IDX_W + 1)'(j);
    assign lane_valid = inst_valid && (lane_idx <= uop_num_ext);

    assign uop_valid[j]          = lane_valid;
    assign uops[j].tag           = inst.tag;
    assign uops[j].opcode        = inst.opcode;
    assign uops[j].uop_index     = lane_idx[IDX_W-1:0];
    // only a valid lane may claim the last uop
    assign uops[j].last_uop_valid = lane_valid && (lane_idx == uop_num_ext);
  end

endmodule

// File: rvv_sync_fifo.sv
/* multi-port synchronous FIFO, payload chosen by a type parameter
   ports are served in order from port 0 and stop at the first idle one */

module rvv_sync_fifo #(
  parameter int  DEPTH     = 8,
  parameter int  WR_PORTS  = 1,
  parameter int  RD_PORTS  = 1,
  parameter type payload_t = logic [7:0]
) (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic     [WR_PORTS-1:0]                    wr_en,
  input  payload_t [WR_PORTS-1:0]                    wr_data,
  input  logic     [RD_PORTS-1:0]                    rd_en,
  output logic     [RD_PORTS-1:0]                    rd_valid,
  output payload_t [RD_PORTS-1:0]                    rd_data,
  output logic                                       full,
  output logic     [(WR_PORTS > 1 ? WR_PORTS-1 : 1):1] almost_full
);

  // depth is a power of two, pointers wrap on their own
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int AF_HI = (WR_PORTS > 1) ? WR_PORTS - 1 : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] free_cnt;
  logic [CNT_W-1:0] wr_num;
  logic [CNT_W-1:0] rd_num;

  assign free_cnt = CNT_W'(DEPTH) - count;
  assign full     = (count == CNT_W'(DEPTH));

  // accepted writes: leading enabled ports that still find room
  always_comb begin
    wr_num = '0;
    for (int i = 0; i < WR_PORTS; i++) begin
      if (wr_en[i] && wr_num == CNT_W'(i) && free_cnt > CNT_W'(i)) begin
        wr_num = wr_num + 1'b1;
      end
    end
  end

  // accepted reads, a pop past the stored entries is ignored
  always_comb begin
    rd_num = '0;
    for (int i = 0; i < RD_PORTS; i++) begin
      if (rd_en[i] && rd_num == CNT_W'(i) && count > CNT_W'(i)) begin
        rd_num = rd_num + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(wr_num);
      rd_ptr <= rd_ptr + PTR_W'(rd_num);
      count  <= count + wr_num - rd_num;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < WR_PORTS; i++) begin
      if (CNT_W'(i) < wr_num) begin
        mem[wr_ptr + PTR_W'(i)] <= wr_data[i];
      end
    end
  end

  // head entries shown on the read ports
  for (genvar i = 0; i < RD_PORTS; i++) begin : g_rd
    assign rd_valid[i] = (count > CNT_W'(i));
    assign rd_data[i]  = mem[rd_ptr + PTR_W'(i)];
  end

  // bit k: fewer than k+1 entries free
  for (genvar k = 1; k <= AF_HI; k++) begin : g_af
    assign almost_full[k] = (free_cnt < CNT_W'(k + 1));
  end

endmodule

// File: rvv_backend_pkg.sv
/* instruction and uop types shared by the decode stage
   referenced as rvv_backend_pkg::name, never imported */

`include "rvv_backend_consts.svh"

package rvv_backend_pkg;

  // instruction as written into the command queue
  // uop_num holds the uop count minus one
  typedef struct packed {
    logic [7:0]                  tag;
    logic [7:0]                  opcode;
    logic [`UOP_INDEX_WIDTH-1:0] uop_num;
  } inst_t;

  // one micro-op as stored in the uop queue
  typedef struct packed {
    logic [7:0]                  tag;
    logic [7:0]                  opcode;
    logic [`UOP_INDEX_WIDTH-1:0] uop_index;
    // set on the final uop of its instruction
    logic                        last_uop_valid;
  } uop_t;

endpackage

// File: rvv_backend_consts.svh
/* lane counts, index width and queue depths of the vector decode stage
   include in any file that sizes ports or storage from these values */

`ifndef RVV_BACKEND_CONSTS_SVH
`define RVV_BACKEND_CONSTS_SVH

// decode units, also command-queue entries looked at per cycle
`define NUM_DE_INST 2

// uops produced by one unit, also uop-queue writes per cycle
`define NUM_DE_UOP 4

// uop index inside one instruction, 1 to 8 uops
`define UOP_INDEX_WIDTH 3

// command queue entries
`define CQ_DEPTH 8

// uop queue entries
// keep at least NUM_DE_UOP so a full write can ever be accepted
`define UQ_DEPTH 16

`endif
